// File: cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    ////////////////////
    // stream word
    localparam int DATA_W = 32;                          // link word width
    localparam logic [DATA_W-1:0] FW_VERSION_DEFAULT = 32'h0003_0102;

    ////////////////////
    // command word
    typedef enum logic [4:0] {
        LOOPBACK = 5'd0,                                 // echo payload
        RD_REG   = 5'd1,                                 // return one register
        WR_REG   = 5'd2                                  // write one register
    } cmd_code_e;

    typedef struct packed {
        logic [26:0] unused;                             // ignored by the decoder
        cmd_code_e   code;                               // low five bits pick the handler
    } cmd_fields_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;                          // echoed or inverted in replies
        cmd_fields_t       f;                            // decoded view
    } cmd_word_u;

    ////////////////////
    // register map
    typedef enum logic [2:0] {
        REG_CHANNEL_TAG  = 3'd0,
        REG_MUON_BURSTS  = 3'd1,
        REG_LASER_BURSTS = 3'd2,
        REG_PED_BURSTS   = 3'd3,
        REG_INIT_FILL    = 3'd4,
        REG_FILL_NUM     = 3'd5,                         // 5..7 read only
        REG_CH_ADDR      = 3'd6,
        REG_VERSION      = 3'd7
    } reg_addr_e;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;                         // final word of frame
    } rx_beat_t;

    ////////////////////
    // reply requests
    typedef enum logic [2:0] {
        CSN,                                             // latched serial number
        CMD,                                             // latched command word
        INV_CMD,                                         // error answer
        RX_DATA,                                         // current rx word
        REG_DATA                                         // register read data
    } reply_src_e;

    typedef struct packed {
        reply_src_e src;
        logic       last;
    } reply_req_t;

    typedef struct packed {
        logic [11:0] channel_tag;
        logic [22:0] muon_num_bursts;
        logic [22:0] laser_num_bursts;
        logic [22:0] ped_num_bursts;
        logic [23:0] initial_fill_num;
    } acq_config_t;

endpackage

`default_nettype wire

// File: register_block.sv
`timescale 1ns/1ps
`default_nettype none

module register_block #(
    parameter logic [cmd_pkg::DATA_W-1:0] FW_VERSION = cmd_pkg::FW_VERSION_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    input  cmd_pkg::reg_addr_e          reg_addr,
    input  logic                        rd_en,
    input  logic                        wr_en,
    input  logic [cmd_pkg::DATA_W-1:0]  wr_data,
    output logic                        illegal_reg,
    output logic [cmd_pkg::DATA_W-1:0]  reg_rdata,
    input  logic [23:0]                 fill_num,
    input  logic [2:0]                  ch_addr,          // jumper pattern
    output cmd_pkg::acq_config_t        acq_config,
    output logic                        initial_fill_num_wr
);

    logic [2:0] ch_addr_q;                               // corrected channel address
    logic       wr_ok;

    assign illegal_reg = (reg_addr >= cmd_pkg::REG_FILL_NUM);    // status words read only
    assign wr_ok       = wr_en && !illegal_reg;

    ////////////////////
    // channel 3 jumpers are fitted as 110
    always_ff @(posedge clk) begin
        ch_addr_q <= (ch_addr == 3'b110) ? 3'b011 : ch_addr;
    end

    ////////////////////
    // writable settings, truncated to field width
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_config          <= '0;
            initial_fill_num_wr <= 1'b0;
        end else begin
            initial_fill_num_wr <= wr_ok && (reg_addr == cmd_pkg::REG_INIT_FILL);
            if (wr_ok) begin
                case (reg_addr)
                    cmd_pkg::REG_CHANNEL_TAG:
                        acq_config.channel_tag      <= wr_data[11:0];
                    cmd_pkg::REG_MUON_BURSTS:
                        acq_config.muon_num_bursts  <= wr_data[22:0];
                    cmd_pkg::REG_LASER_BURSTS:
                        acq_config.laser_num_bursts <= wr_data[22:0];
                    cmd_pkg::REG_PED_BURSTS:
                        acq_config.ped_num_bursts   <= wr_data[22:0];
                    cmd_pkg::REG_INIT_FILL:
                        acq_config.initial_fill_num <= wr_data[23:0];
                    default: ;                           // read only, blocked above
                endcase
            end
        end
    end

    ////////////////////
    // read mux, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (reg_addr)
                cmd_pkg::REG_CHANNEL_TAG:  reg_rdata <= {20'b0, acq_config.channel_tag};
                cmd_pkg::REG_MUON_BURSTS:  reg_rdata <= {9'b0, acq_config.muon_num_bursts};
                cmd_pkg::REG_LASER_BURSTS: reg_rdata <= {9'b0, acq_config.laser_num_bursts};
                cmd_pkg::REG_PED_BURSTS:   reg_rdata <= {9'b0, acq_config.ped_num_bursts};
                cmd_pkg::REG_INIT_FILL:    reg_rdata <= {8'b0, acq_config.initial_fill_num};
                cmd_pkg::REG_FILL_NUM:     reg_rdata <= {8'b0, fill_num};
                cmd_pkg::REG_CH_ADDR:      reg_rdata <= {29'b0, ch_addr_q};
                default:                   reg_rdata <= FW_VERSION;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: reply_out.sv
`timescale 1ns/1ps
`default_nettype none

module reply_out (
    input  logic                        clk,
    input  logic                        reset,
    input  cmd_pkg::reply_req_t         reply_req,
    input  logic                        reply_valid,
    output logic                        reply_ready,
    input  logic [cmd_pkg::DATA_W-1:0]  csn,
    input  cmd_pkg::cmd_word_u          cmd,
    input  logic [cmd_pkg::DATA_W-1:0]  rx_data,          // current rx word, loopback
    input  logic [cmd_pkg::DATA_W-1:0]  reg_rdata,
    output logic [cmd_pkg::DATA_W-1:0]  tx_data,
    output logic                        tx_tlast,
    output logic                        tx_tvalid,
    input  logic                        tx_tready
);

    logic [cmd_pkg::DATA_W-1:0] word_sel;

    // empty, or emptying this cycle
    assign reply_ready = !tx_tvalid || tx_tready;

    always_comb begin
        case (reply_req.src)
            cmd_pkg::CSN:      word_sel = csn;
            cmd_pkg::CMD:      word_sel = cmd.raw;
            cmd_pkg::INV_CMD:  word_sel = ~cmd.raw;      // error marker
            cmd_pkg::RX_DATA:  word_sel = rx_data;
            cmd_pkg::REG_DATA: word_sel = reg_rdata;
            default:           word_sel = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            tx_tvalid <= 1'b0;
        else if (reply_ready)
            tx_tvalid <= reply_valid;
    end

    // word and last held under back-pressure
    always_ff @(posedge clk) begin
        if (reply_valid && reply_ready) begin
            tx_data  <= word_sel;
            tx_tlast <= reply_req.last;
        end
    end

endmodule

`default_nettype wire

// File: cmd_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
    input  logic                        clk,
    input  logic                        reset,
    input  cmd_pkg::rx_beat_t           rx_beat,
    input  logic                        rx_tvalid,
    output logic                        rx_accept,
    output logic [cmd_pkg::DATA_W-1:0]  csn,
    output cmd_pkg::cmd_word_u          cmd,
    output logic                        start_loopback,
    output logic                        start_reg,
    input  logic                        handler_done,
    output cmd_pkg::reply_req_t         reply_req,
    output logic                        reply_valid,
    input  logic                        reply_ready,
    output logic                        idle
);

    typedef enum logic [2:0] {
        D_CSN, D_CMD, D_RUN, D_DRAIN, D_ERR_CSN, D_ERR_CMD
    } state_e;

    state_e state;
    cmd_pkg::cmd_word_u rx_cmd;                          // incoming word seen as a command

    assign rx_cmd.raw  = rx_beat.data;
    assign rx_accept   = !reset &&                       // nothing taken in reset
                         ((state == D_CSN) || (state == D_CMD) || (state == D_DRAIN));
    assign reply_valid = (state == D_ERR_CSN) || (state == D_ERR_CMD);
    assign idle        = (state == D_CSN);               // waiting for a new frame

    always_comb begin
        reply_req = '0;                                  // CSN, not last
        if (state == D_ERR_CMD) begin
            reply_req.src  = cmd_pkg::INV_CMD;
            reply_req.last = 1'b1;
        end
    end

    ////////////////////
    // serial number and command latches
    always_ff @(posedge clk) begin
        if (state == D_CSN && rx_tvalid) begin
            csn     <= rx_beat.data;
            cmd.raw <= '0;                               // short frame answers ~0
        end
        if (state == D_CMD && rx_tvalid)
            cmd.raw <= rx_beat.data;
    end

    ////////////////////
    // frame start fsm
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= D_CSN;
            start_loopback <= 1'b0;
            start_reg      <= 1'b0;
        end else begin
            start_loopback <= 1'b0;                      // strobes last one cycle
            start_reg      <= 1'b0;
            case (state)
                D_CSN: if (rx_tvalid)
                    state <= rx_beat.last ? D_ERR_CSN : D_CMD;
                D_CMD: if (rx_tvalid) begin
                    if (rx_beat.last) begin
                        state <= D_ERR_CSN;              // no payload, treat as unknown
                    end else begin
                        case (rx_cmd.f.code)
                            cmd_pkg::LOOPBACK: begin
                                start_loopback <= 1'b1;
                                state          <= D_RUN;
                            end
                            cmd_pkg::RD_REG, cmd_pkg::WR_REG: begin
                                start_reg <= 1'b1;
                                state     <= D_RUN;
                            end
                            default: state <= D_DRAIN;   // unknown code
                        endcase
                    end
                end
                D_RUN: if (handler_done)
                    state <= D_CSN;
                D_DRAIN: if (rx_tvalid && rx_beat.last)
                    state <= D_ERR_CSN;
                D_ERR_CSN: if (reply_ready)
                    state <= D_ERR_CMD;
                D_ERR_CMD: if (reply_ready)
                    state <= D_CSN;
                default: state <= D_CSN;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: loopback_sm.sv
`timescale 1ns/1ps
`default_nettype none

module loopback_sm (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  cmd_pkg::rx_beat_t   rx_beat,
    input  logic                rx_tvalid,
    output logic                rx_accept,
    output cmd_pkg::reply_req_t reply_req,
    output logic                reply_valid,
    input  logic                reply_ready,
    output logic                done
);

    typedef enum logic [1:0] {L_IDLE, L_CSN, L_CMD, L_DATA} state_e;

    state_e state;
    logic   req_xfer;

    // payload beat and its echo request move together
    assign rx_accept   = (state == L_DATA) && reply_ready;
    assign reply_valid = (state == L_CSN) || (state == L_CMD) ||
                         ((state == L_DATA) && rx_tvalid);
    assign req_xfer    = reply_valid && reply_ready;
    assign done        = (state == L_DATA) && req_xfer && rx_beat.last;

    always_comb begin
        reply_req = '0;
        case (state)
            L_CSN: reply_req.src = cmd_pkg::CSN;
            L_CMD: reply_req.src = cmd_pkg::CMD;
            L_DATA: begin
                reply_req.src  = cmd_pkg::RX_DATA;
                reply_req.last = rx_beat.last;           // copied from rx
            end
            default: reply_req = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= L_IDLE;
        end else begin
            case (state)
                L_IDLE: if (start) state <= L_CSN;
                L_CSN:  if (req_xfer) state <= L_CMD;
                L_CMD:  if (req_xfer) state <= L_DATA;
                L_DATA: if (done) state <= L_IDLE;
                default: state <= L_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: reg_access_sm.sv
`timescale 1ns/1ps
`default_nettype none

module reg_access_sm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        write,            // WR_REG, else RD_REG
    input  cmd_pkg::rx_beat_t           rx_beat,
    input  logic                        rx_tvalid,
    output logic                        rx_accept,
    output cmd_pkg::reg_addr_e          reg_addr,
    output logic                        rd_en,
    output logic                        wr_en,
    output logic [cmd_pkg::DATA_W-1:0]  wr_data,
    input  logic                        illegal_reg,      // target not writable
    output cmd_pkg::reply_req_t         reply_req,
    output logic                        reply_valid,
    input  logic                        reply_ready,
    output logic                        done
);

    typedef enum logic [2:0] {
        R_IDLE, R_ADDR, R_DATA, R_DRAIN, R_CSN, R_CMD, R_RDATA
    } state_e;

    state_e state;
    logic   err;                                         // answer with inverted command
    logic   addr_bad;

    assign addr_bad    = |rx_beat.data[cmd_pkg::DATA_W-1:3];   // only 0..7 exist
    assign rx_accept   = (state == R_ADDR) || (state == R_DATA) || (state == R_DRAIN);
    assign reply_valid = (state == R_CSN) || (state == R_CMD) || (state == R_RDATA);
    assign done        = reply_valid && reply_ready && reply_req.last;

    always_comb begin
        reply_req = '0;
        case (state)
            R_CSN: reply_req.src = cmd_pkg::CSN;
            R_CMD: begin
                reply_req.src  = err ? cmd_pkg::INV_CMD : cmd_pkg::CMD;
                reply_req.last = err || write;           // read still sends data
            end
            R_RDATA: begin
                reply_req.src  = cmd_pkg::REG_DATA;
                reply_req.last = 1'b1;
            end
            default: reply_req = '0;
        endcase
    end

    // address and write data
    always_ff @(posedge clk) begin
        if (state == R_ADDR && rx_tvalid)
            reg_addr <= cmd_pkg::reg_addr_e'(rx_beat.data[2:0]);
        if (state == R_DATA && rx_tvalid)
            wr_data <= rx_beat.data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= R_IDLE;
            err   <= 1'b0;
            rd_en <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            rd_en <= 1'b0;
            wr_en <= 1'b0;
            case (state)
                R_IDLE: if (start) begin
                    err   <= 1'b0;
                    state <= R_ADDR;
                end
                R_ADDR: if (rx_tvalid) begin
                    err   <= addr_bad || (write && rx_beat.last);   // write needs data word
                    rd_en <= !write && !addr_bad;
                    if (rx_beat.last)
                        state <= R_CSN;
                    else
                        state <= write ? R_DATA : R_DRAIN;
                end
                R_DATA: if (rx_tvalid) begin
                    err   <= err || illegal_reg;
                    wr_en <= !(err || illegal_reg);      // single write pulse
                    state <= rx_beat.last ? R_CSN : R_DRAIN;
                end
                R_DRAIN: if (rx_tvalid && rx_beat.last)
                    state <= R_CSN;
                R_CSN: if (reply_ready)
                    state <= R_CMD;
                R_CMD: if (reply_ready)
                    state <= (err || write) ? R_IDLE : R_RDATA;
                R_RDATA: if (reply_ready)
                    state <= R_IDLE;
                default: state <= R_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_top #(
    parameter logic [cmd_pkg::DATA_W-1:0] FW_VERSION = cmd_pkg::FW_VERSION_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    input  cmd_pkg::rx_beat_t           rx_beat,
    input  logic                        rx_tvalid,
    output logic                        rx_tready,
    output logic [cmd_pkg::DATA_W-1:0]  tx_data,
    output logic                        tx_tlast,
    output logic                        tx_tvalid,
    input  logic                        tx_tready,
    input  logic [23:0]                 fill_num,
    input  logic [2:0]                  ch_addr,            // raw jumpers
    output cmd_pkg::acq_config_t        acq_config,
    output logic                        initial_fill_num_wr,
    output logic                        cmd_idle
);

    logic disp_accept, lb_accept, reg_accept;            // per owner rx accepts
    logic disp_valid, lb_valid, reg_valid;
    cmd_pkg::reply_req_t disp_req, lb_req, reg_req;
    cmd_pkg::reply_req_t reply_req;                      // merged request
    logic reply_valid, reply_ready;
    logic [cmd_pkg::DATA_W-1:0] csn;
    cmd_pkg::cmd_word_u cmd;
    logic start_loopback, start_reg, lb_done, reg_done;
    cmd_pkg::reg_addr_e reg_addr;
    logic rd_en, wr_en, illegal_reg;
    logic [cmd_pkg::DATA_W-1:0] wr_data, reg_rdata;

    ////////////////////
    // merge owners, only one is active at a time
    assign rx_tready   = disp_accept | lb_accept | reg_accept;
    assign reply_valid = disp_valid | lb_valid | reg_valid;
    assign reply_req   = cmd_pkg::reply_req_t'(disp_req | lb_req | reg_req);

    cmd_dispatch dispatch_i (
        .clk(clk), .reset(reset),
        .rx_beat(rx_beat), .rx_tvalid(rx_tvalid), .rx_accept(disp_accept),
        .csn(csn), .cmd(cmd),
        .start_loopback(start_loopback), .start_reg(start_reg),
        .handler_done(lb_done | reg_done),
        .reply_req(disp_req), .reply_valid(disp_valid), .reply_ready(reply_ready),
        .idle(cmd_idle)
    );

    loopback_sm loopback_i (
        .clk(clk), .reset(reset), .start(start_loopback),
        .rx_beat(rx_beat), .rx_tvalid(rx_tvalid), .rx_accept(lb_accept),
        .reply_req(lb_req), .reply_valid(lb_valid), .reply_ready(reply_ready),
        .done(lb_done)
    );

    reg_access_sm reg_access_i (
        .clk(clk), .reset(reset), .start(start_reg),
        .write(cmd.f.code == cmd_pkg::WR_REG),           // command stays latched while running
        .rx_beat(rx_beat), .rx_tvalid(rx_tvalid), .rx_accept(reg_accept),
        .reg_addr(reg_addr), .rd_en(rd_en), .wr_en(wr_en), .wr_data(wr_data),
        .illegal_reg(illegal_reg),
        .reply_req(reg_req), .reply_valid(reg_valid), .reply_ready(reply_ready),
        .done(reg_done)
    );

    register_block #(.FW_VERSION(FW_VERSION)) regs_i (
        .clk(clk), .reset(reset),
        .reg_addr(reg_addr), .rd_en(rd_en), .wr_en(wr_en), .wr_data(wr_data),
        .illegal_reg(illegal_reg), .reg_rdata(reg_rdata),
        .fill_num(fill_num), .ch_addr(ch_addr),
        .acq_config(acq_config), .initial_fill_num_wr(initial_fill_num_wr)
    );

    reply_out reply_i (
        .clk(clk), .reset(reset),
        .reply_req(reply_req), .reply_valid(reply_valid), .reply_ready(reply_ready),
        .csn(csn), .cmd(cmd), .rx_data(rx_beat.data), .reg_rdata(reg_rdata),
        .tx_data(tx_data), .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid),
        .tx_tready(tx_tready)
    );

endmodule

`default_nettype wire

// File: cmd_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_chk (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        rx_tready,
    input  wire [cmd_pkg::DATA_W-1:0]  tx_data,
    input  wire                        tx_tlast,
    input  wire                        tx_tvalid,
    input  wire                        tx_tready,
    input  wire                        initial_fill_num_wr,
    input  wire                        cmd_idle
);

    ////////////////////
    // tx word frozen while stalled
    property tx_hold_p;
        @(posedge clk) disable iff (reset)
            (tx_tvalid && !tx_tready) |=> (tx_tvalid && $stable(tx_data) && $stable(tx_tlast));
    endproperty

    // outputs right after a reset edge
    property reset_state_p;
        @(posedge clk) $past(reset) |-> (!tx_tvalid && !initial_fill_num_wr && cmd_idle);
    endproperty

    property no_rx_in_reset_p;
        @(posedge clk) reset |-> !rx_tready;
    endproperty

    assert property (tx_hold_p) else $error("tx word changed while stalled");
    assert property (reset_state_p) else $error("outputs not in reset state");
    assert property (no_rx_in_reset_p) else $error("rx_tready high during reset");

endmodule

`default_nettype wire

// File: cmd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_tb;

    localparam int TIMEOUT = 2000;                       // cycles allowed per wait

    typedef struct packed {
        logic [cmd_pkg::DATA_W-1:0] data;
        logic                       last;
    } tx_beat_t;

    logic                        clk = 1'b0;
    logic                        reset;
    cmd_pkg::rx_beat_t           rx_beat;
    logic                        rx_tvalid;
    logic                        rx_tready;
    logic [cmd_pkg::DATA_W-1:0]  tx_data;
    logic                        tx_tlast;
    logic                        tx_tvalid;
    logic                        tx_tready = 1'b0;       // random once out of reset
    logic [23:0]                 fill_num;
    logic [2:0]                  ch_addr;
    cmd_pkg::acq_config_t        acq_config;
    logic                        initial_fill_num_wr;
    logic                        cmd_idle;

    cmd_pkg::rx_beat_t rx_q[$];                          // beats still to send
    tx_beat_t          exp_q[$];                         // words still expected
    logic [31:0]       lcg_state = 32'd57;
    int                strobe_cnt = 0;
    logic              seen_idle = 1'b0;
    int                beat_idx = 0;                     // tx word index for messages
    int                batch_cnt = 0;

    cmd_top dut_i (
        .clk(clk), .reset(reset),
        .rx_beat(rx_beat), .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
        .tx_data(tx_data), .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid),
        .tx_tready(tx_tready),
        .fill_num(fill_num), .ch_addr(ch_addr),
        .acq_config(acq_config), .initial_fill_num_wr(initial_fill_num_wr),
        .cmd_idle(cmd_idle)
    );

    bind cmd_top cmd_chk chk_i (
        .clk(clk), .reset(reset),
        .rx_tready(rx_tready),
        .tx_data(tx_data), .tx_tlast(tx_tlast), .tx_tvalid(tx_tvalid),
        .tx_tready(tx_tready),
        .initial_fill_num_wr(initial_fill_num_wr), .cmd_idle(cmd_idle)
    );

    always #4 clk = ~clk;                                // 8 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////
    // tx back-pressure
    always @(posedge clk) begin
        #1;
        if (!reset) begin
            lcg_state = lcg_next(lcg_state);
            tx_tready = lcg_state[16];                   // mid bit, low bits repeat fast
        end
    end

    always @(negedge clk) begin
        if (!reset && initial_fill_num_wr)
            strobe_cnt = strobe_cnt + 1;                 // one per strobe cycle
    end

    // idle must show up inside every reply frame
    always @(negedge clk) begin
        if (!reset) begin
            if (cmd_idle)
                seen_idle = 1'b1;
            if (tx_tvalid && tx_tready && tx_tlast) begin
                if (!seen_idle)
                    stop_on_error("cmd_idle stayed low through a whole frame");
                seen_idle = 1'b0;
            end
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    ////////////////////
    // compare tasks
    task automatic check_tx_beat(input logic [cmd_pkg::DATA_W-1:0] got_data,
                                 input logic got_last, input tx_beat_t exp);
        if (got_data !== exp.data || got_last !== exp.last)
            stop_on_error($sformatf("error at %0t: tx word %0d is %h last %b, expected %h last %b",
                $time, beat_idx, got_data, got_last, exp.data, exp.last));
    endtask

    task automatic check_config(input cmd_pkg::acq_config_t got, input cmd_pkg::acq_config_t exp,
                                input int got_strobes, input int exp_strobes);
        if (got !== exp)
            stop_on_error($sformatf("error at %0t: acq_config is %h, expected %h",
                $time, got, exp));
        if (got_strobes != exp_strobes)
            stop_on_error($sformatf("error at %0t: %0d initial fill strobes, expected %0d",
                $time, got_strobes, exp_strobes));
    endtask

    task automatic drive_rx();
        cmd_pkg::rx_beat_t beat;
        int wait_cnt;
        while (rx_q.size() > 0) begin
            beat      = rx_q.pop_front();
            rx_beat   = beat;
            rx_tvalid = 1'b1;
            wait_cnt  = 0;
            @(negedge clk);
            while (!rx_tready) begin                     // held until taken
                wait_cnt++;
                if (wait_cnt > TIMEOUT)
                    stop_on_error("timeout waiting for rx_tready");
                @(negedge clk);
            end
            @(posedge clk);                              // beat moves here
            #1;
        end
        rx_tvalid = 1'b0;
    endtask

    task automatic collect_tx();
        tx_beat_t exp;
        int wait_cnt;
        while (exp_q.size() > 0) begin
            exp      = exp_q.pop_front();
            wait_cnt = 0;
            @(negedge clk);
            while (!(tx_tvalid && tx_tready)) begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT)
                    stop_on_error("timeout waiting for a reply word on tx");
                @(negedge clk);
            end
            check_tx_beat(tx_data, tx_tlast, exp);
            beat_idx++;
        end
    endtask

    // send queued frames back to back, then check settings
    task automatic run_batch(input cmd_pkg::acq_config_t exp_cfg, input int exp_strobes);
        int base;
        int wait_cnt;
        base = strobe_cnt;
        fork
            drive_rx();
            collect_tx();
        join
        repeat (2) begin                                 // last word leaves the register
            @(negedge clk);
            if (tx_tvalid)
                stop_on_error("an extra reply word appeared after the expected ones");
        end
        wait_cnt = 0;
        while (!cmd_idle) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT)
                stop_on_error("timeout waiting for cmd_idle after a batch of frames");
            @(negedge clk);
        end
        check_config(acq_config, exp_cfg, strobe_cnt - base, exp_strobes);
        batch_cnt++;
        @(posedge clk);
        #1;
    endtask

    ////////////////////
    // main sequence
    initial begin
        int fd;
        int n;
        int last_i;
        int strobes;
        string line;
        logic [31:0] d;
        logic [31:0] tag, muon, laser, ped, init;
        logic [2:0] jmp;
        logic [23:0] fnum;
        cmd_pkg::rx_beat_t rb;
        tx_beat_t tb_beat;
        cmd_pkg::acq_config_t exp_cfg;

        reset     = 1'b1;
        rx_beat   = '0;
        rx_tvalid = 1'b0;
        fill_num  = '0;
        ch_addr   = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("cmd_patterns.txt", "r");
        if (fd == 0)
            stop_on_error("cannot open cmd_patterns.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;                                // blank or comment
            case (line[0])
                "R": begin
                    n = $sscanf(line, "R %h %d", d, last_i);
                    if (n != 2)
                        stop_on_error("malformed R line in pattern file");
                    rb.data = d;
                    rb.last = last_i[0];
                    rx_q.push_back(rb);
                end
                "T": begin
                    n = $sscanf(line, "T %h %d", d, last_i);
                    if (n != 2)
                        stop_on_error("malformed T line in pattern file");
                    tb_beat.data = d;
                    tb_beat.last = last_i[0];
                    exp_q.push_back(tb_beat);
                end
                "I": begin
                    n = $sscanf(line, "I %b %h", jmp, fnum);
                    if (n != 2)
                        stop_on_error("malformed I line in pattern file");
                    ch_addr  = jmp;                      // jumpers and fill counter
                    fill_num = fnum;
                end
                "C": begin
                    n = $sscanf(line, "C %h %h %h %h %h %d",
                                tag, muon, laser, ped, init, strobes);
                    if (n != 6)
                        stop_on_error("malformed C line in pattern file");
                    exp_cfg.channel_tag      = tag[11:0];
                    exp_cfg.muon_num_bursts  = muon[22:0];
                    exp_cfg.laser_num_bursts = laser[22:0];
                    exp_cfg.ped_num_bursts   = ped[22:0];
                    exp_cfg.initial_fill_num = init[23:0];
                    run_batch(exp_cfg, strobes);
                end
                default: stop_on_error("unknown line kind in pattern file");
            endcase
        end
        $fclose(fd);

        if (batch_cnt == 0) begin
            stop_on_error("pattern file held no checked frames");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: cmd_patterns.txt
# R rx_word(hex) last | T expected_tx_word(hex) last | I ch_addr(bin) fill_num(hex)
# C channel_tag muon laser ped initial_fill(hex) fill_strobes(dec), runs frames above it
R 00000011 0
R 5a000000 0
R deadbeef 0
R 01234567 0
R 89abcdef 1
T 00000011 0
T 5a000000 0
T deadbeef 0
T 01234567 0
T 89abcdef 1
C 000 000000 000000 000000 000000 0
# write muon bursts, read it back in the next frame
R 00000012 0
R 00000002 0
R 00000001 0
R ffffffff 1
T 00000012 0
T 00000002 1
R 00000013 0
R 00000001 0
R 00000001 1
T 00000013 0
T 00000001 0
T 007fffff 1
C 000 7fffff 000000 000000 000000 0
R 00000014 0
R 00000002 0
R 00000004 0
R 12abcdef 1
T 00000014 0
T 00000002 1
C 000 7fffff 000000 000000 abcdef 1
I 110 000123
R 00000015 0
R 00000001 0
R 00000006 1
T 00000015 0
T 00000001 0
T 00000003 1
R 00000016 0
R 00000001 0
R 00000007 1
T 00000016 0
T 00000001 0
T 00030102 1
R 00000017 0
R 00000001 0
R 00000005 1
T 00000017 0
T 00000001 0
T 00000123 1
C 000 7fffff 000000 000000 abcdef 0
I 101 000123
R 00000018 0
R 00000001 0
R 00000006 1
T 00000018 0
T 00000001 0
T 00000005 1
C 000 7fffff 000000 000000 abcdef 0
# error answers: read-only write, address 9, unknown code 7
R 00000019 0
R 00000002 0
R 00000007 0
R 00000055 1
T 00000019 0
T fffffffd 1
R 0000001a 0
R 00000001 0
R 00000009 1
T 0000001a 0
T fffffffe 1
R 0000001b 0
R 00000007 0
R 00000000 1
T 0000001b 0
T fffffff8 1
C 000 7fffff 000000 000000 abcdef 0

// File: cmd_proc.f
cmd_pkg.sv
register_block.sv
reply_out.sv
cmd_dispatch.sv
loopback_sm.sv
reg_access_sm.sv
cmd_top.sv
cmd_chk.sv
cmd_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module cmd_tb -f cmd_proc.f -o cmd_sim
./obj_dir/cmd_sim
